/* src/kbd_pkg.sv */
`default_nettype none

package kbd_pkg;

    typedef logic [7:0] code_t;                 // one scan-code byte

    // set 2 make codes of the keys in use
    localparam code_t KEY_0       = 8'h70;
    localparam code_t KEY_1       = 8'h69;
    localparam code_t KEY_2       = 8'h72;
    localparam code_t KEY_3       = 8'h7A;
    localparam code_t KEY_4       = 8'h6B;
    localparam code_t KEY_5       = 8'h73;
    localparam code_t KEY_6       = 8'h74;
    localparam code_t KEY_7       = 8'h6C;
    localparam code_t KEY_8       = 8'h75;
    localparam code_t KEY_9       = 8'h7D;
    localparam code_t KEY_PLUS    = 8'h79;     // keypad plus
    localparam code_t KEY_MINUS   = 8'h7B;     // keypad minus
    localparam code_t KEY_EQUALS  = 8'h55;
    localparam code_t KEY_RELEASE = 8'hF0;     // break prefix

    typedef enum logic [2:0] {
        DIGIT,
        PLUS,
        MINUS,
        EQUALS,
        RELEASE,
        OTHER                                   // any code not in the table
    } key_kind_t;

    typedef logic [3:0] digit_t;                // decimal 0..9

    typedef enum logic {
        OP_ADD,
        OP_SUB
    } op_t;

    typedef logic signed [5:0] result_t;        // -9..18 fits with room to spare

endpackage

`default_nettype wire

/* src/disp_pkg.sv */
`default_nettype none

package disp_pkg;

    typedef logic [6:0] seg_t;                  // active low, bit 0 is segment a

    typedef enum logic [2:0] {
        G_BLANK,
        G_DIGIT,                                // value comes with the field
        G_PLUS,
        G_MINUS,
        G_EQUALS,
        G_ERROR
    } glyph_t;

    localparam seg_t SEG_BLANK  = 7'b1111111;   // all segments off
    localparam seg_t SEG_PLUS   = 7'b0001111;
    localparam seg_t SEG_MINUS  = 7'b0111111;   // segment g only
    localparam seg_t SEG_EQUALS = 7'b0110111;   // segments d and g
    localparam seg_t SEG_E      = 7'b0000110;

    // digit patterns, index is the digit value
    localparam seg_t SEG_DIGITS [10] = '{
        7'b1000000,                             // 0
        7'b1111001,                             // 1
        7'b0100100,                             // 2
        7'b0110000,                             // 3
        7'b0011001,                             // 4
        7'b0010010,                             // 5
        7'b0000010,                             // 6
        7'b1111000,                             // 7
        7'b0000000,                             // 8
        7'b0010000                              // 9
    };

endpackage

`default_nettype wire

/* src/calc_display_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface calc_display_if import kbd_pkg::*, disp_pkg::*; ();

    glyph_t  first_kind;                        // first operand field
    digit_t  first_val;
    glyph_t  sign_kind;                         // operator field
    glyph_t  second_kind;                       // second operand field
    digit_t  second_val;
    glyph_t  eq_kind;                           // equals mark
    logic    result_show;                       // result fields lit
    result_t result;                            // signed sum or difference

    modport fsm (
        output first_kind, first_val, sign_kind, second_kind, second_val,
               eq_kind, result_show, result
    );

    modport enc (
        input  first_kind, first_val, sign_kind, second_kind, second_val,
               eq_kind, result_show, result
    );

endinterface

`default_nettype wire

/* src/ps2_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx import kbd_pkg::*; #(
    parameter int FILTER_DEPTH = 6              // keyboard clock samples in the window
) (
    input  wire   clk,
    input  wire   reset,
    input  wire   keyb_clk,
    input  wire   keyb_data,
    output code_t code,
    output logic  code_valid
);

    localparam int HALF = FILTER_DEPTH / 2;
    // newest samples sit at the top, so a fall shows as lows above highs
    localparam logic [FILTER_DEPTH-1:0] FALL_PATTERN = {{HALF{1'b0}}, {HALF{1'b1}}};

    logic [FILTER_DEPTH-1:0] clk_samples;       // keyboard clock history
    logic [1:0]              data_sync;         // two-flop sync of keyboard data
    logic [10:0]             frame;             // stop, parity, data[7:0], start
    logic                    clk_fall;

    if (FILTER_DEPTH < 4 || FILTER_DEPTH % 2 != 0) begin : g_bad_depth
        $error("FILTER_DEPTH must be even and at least 4");
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            clk_samples <= '1;                  // idle line is high
            data_sync   <= 2'b11;
        end
        else
        begin
            clk_samples <= {keyb_clk, clk_samples[FILTER_DEPTH-1:1]}; // shift in from the top
            data_sync   <= {data_sync[0], keyb_data};
        end
    end

    assign clk_fall = (clk_samples == FALL_PATTERN); // clean edge after glitch filter

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            frame <= '1;
        else if (!frame[0])
            frame <= '1;                        // byte taken, start over
        else if (clk_fall)
            frame <= {data_sync[1], frame[10:1]}; // lsb first, start bit ends in bit 0
    end

    assign code       = frame[8:1];             // data byte once the frame is full
    assign code_valid = ~frame[0];              // start bit has reached the bottom

    // a keyboard clock fall in the cycle the frame is cleared would be lost
    a_no_lost_edge: assert property (@(posedge clk) disable iff (reset)
        code_valid |-> !clk_fall);

endmodule

`default_nettype wire

/* src/key_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module key_classifier import kbd_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  code_t     code,
    input  wire       code_valid,
    output logic      key_valid,
    output key_kind_t key_kind,
    output digit_t    key_digit
);

    key_kind_t next_kind;
    digit_t    next_digit;

    always_comb
    begin
        next_kind  = DIGIT;                     // most table entries are digits
        next_digit = 4'd0;
        case (code)
            KEY_0:       next_digit = 4'd0;
            KEY_1:       next_digit = 4'd1;
            KEY_2:       next_digit = 4'd2;
            KEY_3:       next_digit = 4'd3;
            KEY_4:       next_digit = 4'd4;
            KEY_5:       next_digit = 4'd5;
            KEY_6:       next_digit = 4'd6;
            KEY_7:       next_digit = 4'd7;
            KEY_8:       next_digit = 4'd8;
            KEY_9:       next_digit = 4'd9;
            KEY_PLUS:    next_kind  = PLUS;
            KEY_MINUS:   next_kind  = MINUS;
            KEY_EQUALS:  next_kind  = EQUALS;
            KEY_RELEASE: next_kind  = RELEASE;
            default:     next_kind  = OTHER;    // unknown key or extended prefix
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            key_valid <= 1'b0;
        else
            key_valid <= code_valid;            // one cycle behind the byte
    end

    always_ff @(posedge clk)
    begin
        if (code_valid)
        begin
            key_kind  <= next_kind;
            key_digit <= next_digit;
        end
    end

endmodule

`default_nettype wire

/* src/calc_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_fsm import kbd_pkg::*, disp_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           key_valid,
    input  key_kind_t     key_kind,
    input  digit_t        key_digit,
    calc_display_if.fsm   disp
);

    typedef enum logic [2:0] {
        WAIT_OPERAND1,
        WAIT_OPERATOR,
        WAIT_OPERAND2,
        WAIT_EQ,
        WAIT_RELEASE,                           // waiting for the f0 prefix
        AFTER_RELEASE                           // waiting for the repeated code
    } state_t;

    state_t  state;
    state_t  step;                              // entry step of the last key
    logic    error;                             // last key was wrong for its step
    digit_t  operand1;
    digit_t  operand2;
    op_t     op;
    result_t opnd1_ext;
    result_t opnd2_ext;

    // entry step that follows a given one
    function automatic state_t next_step(input state_t cur);
        state_t nxt;
        case (cur)
            WAIT_OPERAND1: nxt = WAIT_OPERATOR;
            WAIT_OPERATOR: nxt = WAIT_OPERAND2;
            WAIT_OPERAND2: nxt = WAIT_EQ;
            default:       nxt = WAIT_OPERAND1; // after equals a new sum starts
        endcase
        return nxt;
    endfunction

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state            <= WAIT_OPERAND1;
            step             <= WAIT_OPERAND1;
            error            <= 1'b0;
            op               <= OP_ADD;
            disp.first_kind  <= G_BLANK;
            disp.sign_kind   <= G_BLANK;
            disp.second_kind <= G_BLANK;
            disp.eq_kind     <= G_BLANK;
            disp.result_show <= 1'b0;
        end
        else if (key_valid)
        begin
            case (state)
                WAIT_OPERAND1:
                begin
                    step  <= WAIT_OPERAND1;
                    state <= WAIT_RELEASE;
                    if (key_kind == DIGIT)
                    begin
                        error            <= 1'b0;
                        operand1         <= key_digit;
                        disp.first_kind  <= G_DIGIT;
                        disp.first_val   <= key_digit;
                        disp.sign_kind   <= G_BLANK; // new sum clears the rest
                        disp.second_kind <= G_BLANK;
                        disp.eq_kind     <= G_BLANK;
                        disp.result_show <= 1'b0;
                    end
                    else
                    begin
                        error           <= 1'b1;
                        disp.first_kind <= G_ERROR;
                    end
                end

                WAIT_OPERATOR:
                begin
                    step  <= WAIT_OPERATOR;
                    state <= WAIT_RELEASE;
                    if (key_kind == PLUS || key_kind == MINUS)
                    begin
                        error            <= 1'b0;
                        op               <= (key_kind == MINUS) ? OP_SUB : OP_ADD;
                        disp.sign_kind   <= (key_kind == MINUS) ? G_MINUS : G_PLUS;
                        disp.second_kind <= G_BLANK;
                        disp.eq_kind     <= G_BLANK;
                        disp.result_show <= 1'b0;
                    end
                    else
                    begin
                        error          <= 1'b1;
                        disp.sign_kind <= G_ERROR;
                    end
                end

                WAIT_OPERAND2:
                begin
                    step  <= WAIT_OPERAND2;
                    state <= WAIT_RELEASE;
                    if (key_kind == DIGIT)
                    begin
                        error            <= 1'b0;
                        operand2         <= key_digit;
                        disp.second_kind <= G_DIGIT;
                        disp.second_val  <= key_digit;
                        disp.eq_kind     <= G_BLANK;
                        disp.result_show <= 1'b0;
                    end
                    else
                    begin
                        error            <= 1'b1;
                        disp.second_kind <= G_ERROR;
                    end
                end

                WAIT_EQ:
                begin
                    step  <= WAIT_EQ;
                    state <= WAIT_RELEASE;
                    if (key_kind == EQUALS)
                    begin
                        error            <= 1'b0;
                        disp.eq_kind     <= G_EQUALS;
                        disp.result_show <= 1'b1; // operands are already stored
                    end
                    else
                    begin
                        error        <= 1'b1;
                        disp.eq_kind <= G_ERROR;
                    end
                end

                WAIT_RELEASE:
                begin
                    if (key_kind == RELEASE)
                        state <= AFTER_RELEASE; // typematic repeats fall through here
                end

                AFTER_RELEASE:
                begin
                    // the repeated code closes the key press
                    state <= error ? step : next_step(step);
                end

                default: state <= WAIT_OPERAND1;
            endcase
        end
    end

    assign opnd1_ext   = result_t'({2'b00, operand1}); // zero-extend into signed width
    assign opnd2_ext   = result_t'({2'b00, operand2});
    assign disp.result = (op == OP_SUB) ? (opnd1_ext - opnd2_ext) : (opnd1_ext + opnd2_ext);

    // single-digit operands keep any shown result inside the display range
    a_result_range: assert property (@(posedge clk) disable iff (reset)
        disp.result_show |-> (disp.result >= -9 && disp.result <= 18));

endmodule

`default_nettype wire

/* src/seg7_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_encoder import kbd_pkg::*, disp_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    calc_display_if.enc disp,
    output seg_t        first_out,
    output seg_t        sign_out,
    output seg_t        second_out,
    output seg_t        eq_out,
    output seg_t        res1_out,
    output seg_t        res2_out
);

    result_t magnitude;                         // absolute value of a negative result
    result_t over_ten;                          // result minus ten
    seg_t    res1_next;
    seg_t    res2_next;

    function automatic seg_t digit_seg(input digit_t val);
        return (val <= 4'd9) ? SEG_DIGITS[val] : SEG_E; // out of range shows E
    endfunction

    function automatic seg_t glyph_seg(input glyph_t kind, input digit_t val);
        seg_t seg;
        case (kind)
            G_DIGIT:  seg = digit_seg(val);
            G_PLUS:   seg = SEG_PLUS;
            G_MINUS:  seg = SEG_MINUS;
            G_EQUALS: seg = SEG_EQUALS;
            G_ERROR:  seg = SEG_E;
            default:  seg = SEG_BLANK;
        endcase
        return seg;
    endfunction

    assign magnitude = -disp.result;
    assign over_ten  = disp.result - 6'sd10;

    // split the signed result into a sign or tens field and a units field
    always_comb
    begin
        if (!disp.result_show)
        begin
            res1_next = SEG_BLANK;
            res2_next = SEG_BLANK;
        end
        else if (disp.result < 0)
        begin
            res1_next = SEG_MINUS;
            res2_next = digit_seg(magnitude[3:0]);
        end
        else if (disp.result < 10)
        begin
            res1_next = SEG_BLANK;              // single digit
            res2_next = digit_seg(disp.result[3:0]);
        end
        else
        begin
            res1_next = SEG_DIGITS[1];          // tens digit is always one
            res2_next = digit_seg(over_ten[3:0]);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            first_out  <= SEG_BLANK;
            sign_out   <= SEG_BLANK;
            second_out <= SEG_BLANK;
            eq_out     <= SEG_BLANK;
            res1_out   <= SEG_BLANK;
            res2_out   <= SEG_BLANK;
        end
        else
        begin
            first_out  <= glyph_seg(disp.first_kind, disp.first_val);
            sign_out   <= glyph_seg(disp.sign_kind, 4'd0);    // no value on the sign
            second_out <= glyph_seg(disp.second_kind, disp.second_val);
            eq_out     <= glyph_seg(disp.eq_kind, 4'd0);
            res1_out   <= res1_next;
            res2_out   <= res2_next;
        end
    end

endmodule

`default_nettype wire

/* src/ps2_calc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_calc_top import kbd_pkg::*, disp_pkg::*; #(
    parameter int FILTER_DEPTH = 6              // keyboard clock filter window
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  keyb_clk,
    input  wire  keyb_data,
    output seg_t first_out,
    output seg_t sign_out,
    output seg_t second_out,
    output seg_t eq_out,
    output seg_t res1_out,
    output seg_t res2_out
);

    code_t     code;                            // received byte
    logic      code_valid;
    logic      key_valid;                       // classified key event
    key_kind_t key_kind;
    digit_t    key_digit;

    calc_display_if disp_if ();                 // fields from fsm to encoder

    ps2_frame_rx #(.FILTER_DEPTH(FILTER_DEPTH)) rx0 (
        .clk, .reset, .keyb_clk, .keyb_data,
        .code, .code_valid
    );

    key_classifier cls0 (
        .clk, .reset, .code, .code_valid,
        .key_valid, .key_kind, .key_digit
    );

    calc_fsm fsm0 (
        .clk, .reset, .key_valid, .key_kind, .key_digit,
        .disp(disp_if.fsm)
    );

    seg7_encoder enc0 (
        .clk, .reset, .disp(disp_if.enc),
        .first_out, .sign_out, .second_out, .eq_out, .res1_out, .res2_out
    );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8                 // full clock period
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;         // even duty cycle

endmodule

`default_nettype wire

/* tests/ps2_calc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_calc_tb import kbd_pkg::*, disp_pkg::*; ();

    localparam int CLK_NS      = 8;
    localparam int N_PRESSES   = 300;
    localparam int HALF_BIT    = 10;            // clk cycles per keyboard clock half-period
    localparam int BYTE_GAP    = 4;             // idle keyboard clock between frames
    localparam int IDLE_CYCLES = 40;            // settle time after each key press
    // four frames of eleven bits per press, plus a fifth on top
    localparam int WATCHDOG_NS = (N_PRESSES * 4 * 11 * 2 * HALF_BIT * CLK_NS) * 12 / 10;

    localparam code_t DIGIT_CODES [10] = '{KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
                                           KEY_5, KEY_6, KEY_7, KEY_8, KEY_9};
    localparam code_t UNKNOWN_CODES [3] = '{8'h29, 8'h1C, 8'h5A}; // space, A, enter

    logic        clk;
    logic        reset;
    logic        keyb_clk;
    logic        keyb_data;
    seg_t        first_out, sign_out, second_out, eq_out, res1_out, res2_out;

    logic [31:0] seed = 32'h48ad_5798;
    int          errors = 0;
    int          checks = 0;
    int          press_no = 0;

    // reference model of the calculator
    int          step = 0;                      // 0 operand1, 1 operator, 2 operand2, 3 equals
    digit_t      op1, op2;
    bit          op_sub;
    seg_t        exp_first, exp_sign, exp_second, exp_eq, exp_res1, exp_res2;

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) clkgen0 (.clk);

    ps2_calc_top #(.FILTER_DEPTH(6)) dut0 (
        .clk, .reset, .keyb_clk, .keyb_data,
        .first_out, .sign_out, .second_out, .eq_out, .res1_out, .res2_out
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pick(input int n);
        seed = lcg_step(seed);
        return int'(seed[30:16]) % n;           // upper bits have the longer period
    endfunction

    // a valid key that does not belong to the current step
    function automatic code_t wrong_class_code(input int cur_step);
        code_t c;
        int    k;
        if (cur_step == 0 || cur_step == 2)
        begin
            k = pick(3);
            c = (k == 0) ? KEY_PLUS : (k == 1) ? KEY_MINUS : KEY_EQUALS;
        end
        else if (cur_step == 1)
        begin
            k = pick(11);
            c = (k < 10) ? DIGIT_CODES[4'(k)] : KEY_EQUALS;
        end
        else
        begin
            k = pick(12);
            c = (k < 10) ? DIGIT_CODES[4'(k)] : (k == 10) ? KEY_PLUS : KEY_MINUS;
        end
        return c;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;                                     // drive just after the edge
    endtask

    // start, data lsb first, parity, stop
    task automatic send_byte(input code_t b);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, 1'b1, b, 1'b0};
        for (i = 0; i < 11; i++)
        begin
            keyb_data = bits[i];                // data settles while clock is high
            wait_cycles(HALF_BIT);
            keyb_clk = 1'b0;
            wait_cycles(HALF_BIT);
            keyb_clk = 1'b1;
        end
        keyb_data = 1'b1;
        wait_cycles(BYTE_GAP);
    endtask

    task automatic press_key(input code_t c, input bit repeat_make);
        send_byte(c);
        if (repeat_make)
            send_byte(c);                       // typematic repeat before release
        send_byte(KEY_RELEASE);
        send_byte(c);
        wait_cycles(IDLE_CYCLES);
    endtask

    task automatic clear_after(input int from);
        if (from <= 1)
            exp_sign = SEG_BLANK;
        if (from <= 2)
            exp_second = SEG_BLANK;
        exp_eq   = SEG_BLANK;
        exp_res1 = SEG_BLANK;                   // result hidden until equals
        exp_res2 = SEG_BLANK;
    endtask

    task automatic update_model(input bit accepted, input digit_t d, input bit sub);
        int res;
        case (step)
            0:
                if (accepted)
                begin
                    op1       = d;
                    exp_first = SEG_DIGITS[d];
                    clear_after(1);
                end
                else
                    exp_first = SEG_E;
            1:
                if (accepted)
                begin
                    op_sub   = sub;
                    exp_sign = sub ? SEG_MINUS : SEG_PLUS;
                    clear_after(2);
                end
                else
                    exp_sign = SEG_E;
            2:
                if (accepted)
                begin
                    op2        = d;
                    exp_second = SEG_DIGITS[d];
                    clear_after(3);
                end
                else
                    exp_second = SEG_E;
            default:
                if (accepted)
                begin
                    exp_eq = SEG_EQUALS;
                    res    = op_sub ? int'(op1) - int'(op2) : int'(op1) + int'(op2);
                    if (res < 0)
                    begin
                        exp_res1 = SEG_MINUS;
                        exp_res2 = SEG_DIGITS[4'(-res)];
                    end
                    else if (res < 10)
                    begin
                        exp_res1 = SEG_BLANK;
                        exp_res2 = SEG_DIGITS[4'(res)];
                    end
                    else
                    begin
                        exp_res1 = SEG_DIGITS[1]; // tens digit
                        exp_res2 = SEG_DIGITS[4'(res - 10)];
                    end
                end
                else
                    exp_eq = SEG_E;
        endcase
        if (accepted)
            step = (step + 1) % 4;              // wrong keys keep the step
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b after press %0d",
                     $time, name, got, exp, press_no);
        end
    endtask

    task automatic check_outputs();
        check_seg("first_out", first_out, exp_first);
        check_seg("sign_out", sign_out, exp_sign);
        check_seg("second_out", second_out, exp_second);
        check_seg("eq_out", eq_out, exp_eq);
        check_seg("res1_out", res1_out, exp_res1);
        check_seg("res2_out", res2_out, exp_res2);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all key presses were sent");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        int     roll;
        digit_t d;
        bit     sub;
        bit     accepted;
        bit     extra;
        code_t  code;
        reset     = 1'b1;
        keyb_clk  = 1'b1;                       // idle bus
        keyb_data = 1'b1;
        exp_first = SEG_BLANK;
        clear_after(0);
        wait_cycles(4);
        reset = 1'b0;
        wait_cycles(4);
        check_outputs();                        // all blank out of reset
        for (press_no = 1; press_no <= N_PRESSES; press_no++)
        begin
            roll     = pick(100);
            extra    = (pick(10) == 0);
            d        = 4'd0;
            sub      = 1'b0;
            accepted = 1'b0;
            if (roll < 60)
            begin
                accepted = 1'b1;
                case (step)
                    0, 2:
                    begin
                        d    = digit_t'(pick(10));
                        code = DIGIT_CODES[d];
                    end
                    1:
                    begin
                        sub  = (pick(2) == 1);
                        code = sub ? KEY_MINUS : KEY_PLUS;
                    end
                    default: code = KEY_EQUALS;
                endcase
            end
            else if (roll < 75)
                code = wrong_class_code(step);
            else
                code = UNKNOWN_CODES[2'(pick(3))];
            press_key(code, extra);
            update_model(accepted, d, sub);
            check_outputs();
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/kbd_pkg.sv
src/disp_pkg.sv
src/calc_display_if.sv
src/ps2_frame_rx.sv
src/key_classifier.sv
src/calc_fsm.sv
src/seg7_encoder.sv
src/ps2_calc_top.sv
tests/tb_clock_gen.sv
tests/ps2_calc_tb.sv

/* Makefile */
# Verilator build and run of the PS/2 calculator testbench

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= ps2_calc_tb
RTL_TOP   ?= ps2_calc_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
